//--- src/invader_pkg.sv
`default_nettype none

package invader_pkg;

	//////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////

	// Screen coordinate, wide enough for 640x480 and margin
	typedef logic [10:0] coord_t;
	// Colour byte, blue | green | red
	typedef logic [7:0] rgb_t;
	typedef logic [1:0] game_mode_t;

	// Game modes, only play moves anything
	localparam game_mode_t MODE_IDLE_0 = 2'd0;
	localparam game_mode_t MODE_IDLE_1 = 2'd1;
	localparam game_mode_t MODE_PLAY   = 2'd2;
	localparam game_mode_t MODE_IDLE_3 = 2'd3;

	//////////////////////////////////////////////////
	// Geometry
	//////////////////////////////////////////////////

	// Screen edges and scoreboard band
	localparam coord_t SCREEN_LEFT       = 11'd0;
	localparam coord_t SCREEN_RIGHT      = 11'd640;
	localparam coord_t SCOREBOARD_BOTTOM = 11'd40;

	// Ship sits on a fixed row
	localparam coord_t SHIP_TOP     = 11'd420;
	localparam coord_t SHIP_BOTTOM  = 11'd430;
	localparam coord_t SHIP_LENGTH  = 11'd40;
	localparam coord_t SHIP_START_X = 11'd320;

	// Shot spawns just above the ship
	localparam coord_t LASER_HEIGHT  = 11'd10;
	localparam coord_t LASER_LENGTH  = 11'd3;
	localparam coord_t LASER_START_Y = 11'd417;

	// Target sprite sizes
	localparam coord_t SAUCER_HEIGHT = 11'd15;
	localparam coord_t SAUCER_LENGTH = 11'd40;
	localparam coord_t ALIEN_HEIGHT  = 11'd16;
	localparam coord_t ALIEN_LENGTH  = 11'd30;

	// One pixel per frame for ship and shot
	localparam coord_t STEP       = 11'd1;
	localparam int     NUM_ALIENS = 8;

	localparam rgb_t COLOR_SHIP  = 8'h78;
	localparam rgb_t COLOR_LASER = 8'hFF;

	//////////////////////////////////////////////////
	// Shared structs
	//////////////////////////////////////////////////

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_pos_t;

	typedef struct packed {
		logic left;
		logic right;
		logic shoot;
	} ship_cmd_t;

	typedef struct packed {
		pixel_pos_t                   saucer;
		pixel_pos_t [NUM_ALIENS-1:0]  aliens;
	} target_set_t;

	typedef struct packed {
		logic on;
		rgb_t rgb;
	} sprite_pix_t;

endpackage

`default_nettype wire

//--- src/ship_controls.sv
`timescale 1ns/1ps
`default_nettype none

module ship_controls (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          restart,
	input  wire invader_pkg::game_mode_t mode,
	input  wire invader_pkg::ship_cmd_t  buttons,
	input  wire invader_pkg::pixel_pos_t scan_pos,
	output logic                         frame_tick,
	output logic                         play_clear,
	output invader_pkg::coord_t          ship_x,
	output logic                         shoot_req
);

	import invader_pkg::*;

	// Travel limits for the ship centre
	localparam coord_t X_MIN = SCREEN_LEFT + SHIP_LENGTH / 2;
	localparam coord_t X_MAX = SCREEN_RIGHT - SHIP_LENGTH / 2;

	logic scan_origin;
	logic in_play;

	//////////////////////////////////////////////////
	// Mode and frame decode
	//////////////////////////////////////////////////

	assign scan_origin = (scan_pos.x == '0) && (scan_pos.y == '0);
	assign in_play     = (mode == MODE_PLAY);

	// One tick per frame, at the top left pixel
	assign frame_tick = scan_origin && in_play;

	// Idle modes and restart hold everything at its start position
	assign play_clear = reset || restart || !in_play;

	assign shoot_req = frame_tick && buttons.shoot;

	//////////////////////////////////////////////////
	// Ship position
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (play_clear) begin
			ship_x <= SHIP_START_X;
		end else if (frame_tick) begin
			// Right button has priority when both are held
			if (buttons.right) begin
				if (ship_x < X_MAX) begin
					ship_x <= ship_x + STEP;
				end
			end else if (buttons.left && ship_x > X_MIN) begin
				ship_x <= ship_x - STEP;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/target_hit.sv
`timescale 1ns/1ps
`default_nettype none

module target_hit (
	input  wire invader_pkg::pixel_pos_t  laser_pos,
	input  wire                           laser_active,
	input  wire invader_pkg::target_set_t targets,
	output logic                          hit
);

	import invader_pkg::*;

	// Ceiling is the bottom of the scoreboard band
	localparam coord_t CEILING_Y = SCOREBOARD_BOTTOM + LASER_HEIGHT / 2 + STEP;

	logic ceiling_hit;
	logic saucer_hit;
	logic alien_hit;

	// Shot has reached the lower edge of a target and lies across its width.
	// Written as x + half >= tx so a target near x 0 does not wrap
	function automatic logic in_box(pixel_pos_t shot, pixel_pos_t tgt,
			coord_t half_len, coord_t half_ht);
		logic below_ok;
		logic x_ok;
		below_ok = (shot.y <= tgt.y + half_ht + STEP);
		x_ok     = (shot.x + half_len >= tgt.x) && (shot.x <= tgt.x + half_len);
		return below_ok && x_ok;
	endfunction

	assign ceiling_hit = (laser_pos.y <= CEILING_Y);

	assign saucer_hit = in_box(laser_pos, targets.saucer,
		SAUCER_LENGTH / 2, SAUCER_HEIGHT / 2);

	always_comb begin
		alien_hit = 1'b0;
		for (int i = 0; i < NUM_ALIENS; i++) begin
			if (in_box(laser_pos, targets.aliens[i], ALIEN_LENGTH / 2, ALIEN_HEIGHT / 2)) begin
				alien_hit = 1'b1;
			end
		end
	end

	// Only a shot in flight can hit anything
	assign hit = laser_active && (ceiling_hit || saucer_hit || alien_hit);

endmodule

`default_nettype wire

//--- src/laser_track.sv
`timescale 1ns/1ps
`default_nettype none

module laser_track (
	input  wire                          clk,
	input  wire                          play_clear,
	input  wire                          frame_tick,
	input  wire                          shoot_req,
	input  wire invader_pkg::coord_t     ship_x,
	input  wire                          hit,
	output invader_pkg::pixel_pos_t      laser_pos,
	output logic                         laser_active
);

	import invader_pkg::*;

	// Where a new or retired shot sits, on top of the ship
	pixel_pos_t dock_pos;

	assign dock_pos.x = ship_x;
	assign dock_pos.y = LASER_START_Y;

	//////////////////////////////////////////////////
	// Shot state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (play_clear) begin
			// Ship is recentred on the same edge
			laser_active <= 1'b0;
			laser_pos.x  <= SHIP_START_X;
			laser_pos.y  <= LASER_START_Y;
		end else if (frame_tick) begin
			if (!laser_active) begin
				// Launch from the current ship column
				if (shoot_req) begin
					laser_active <= 1'b1;
					laser_pos    <= dock_pos;
				end
			end else if (hit) begin
				// Retire and go back to the ship
				laser_active <= 1'b0;
				laser_pos    <= dock_pos;
			end else begin
				// Climb one pixel, column stays fixed
				laser_pos.y <= laser_pos.y - STEP;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/pixel_render.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_render (
	input  wire                          clk,
	input  wire                          reset,
	input  wire invader_pkg::pixel_pos_t scan_pos,
	input  wire invader_pkg::coord_t     ship_x,
	input  wire invader_pkg::pixel_pos_t laser_pos,
	input  wire                          laser_active,
	output invader_pkg::sprite_pix_t     ship_pix,
	output invader_pkg::sprite_pix_t     laser_pix
);

	import invader_pkg::*;

	localparam coord_t SHIP_HALF_X  = SHIP_LENGTH / 2;
	localparam coord_t LASER_HALF_X = LASER_LENGTH / 2;
	localparam coord_t LASER_HALF_Y = LASER_HEIGHT / 2;

	logic ship_on;
	logic laser_on;

	//////////////////////////////////////////////////
	// Coverage of the current scan pixel
	//////////////////////////////////////////////////

	// Ship box, fixed rows
	assign ship_on = (scan_pos.y >= SHIP_TOP) && (scan_pos.y <= SHIP_BOTTOM)
		&& (scan_pos.x + SHIP_HALF_X >= ship_x)
		&& (scan_pos.x <= ship_x + SHIP_HALF_X);

	// Shot box around its centre, drawn only in flight
	assign laser_on = laser_active
		&& (scan_pos.y + LASER_HALF_Y >= laser_pos.y)
		&& (scan_pos.y <= laser_pos.y + LASER_HALF_Y)
		&& (scan_pos.x + LASER_HALF_X >= laser_pos.x)
		&& (scan_pos.x <= laser_pos.x + LASER_HALF_X);

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ship_pix  <= '0;
			laser_pix <= '0;
		end else begin
			ship_pix.on   <= ship_on;
			ship_pix.rgb  <= ship_on ? COLOR_SHIP : '0;
			laser_pix.on  <= laser_on;
			laser_pix.rgb <= laser_on ? COLOR_LASER : '0;
		end
	end

endmodule

`default_nettype wire

//--- src/ship_laser_top.sv
`timescale 1ns/1ps
`default_nettype none

module ship_laser_top (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           restart,
	input  wire invader_pkg::game_mode_t  mode,
	input  wire invader_pkg::ship_cmd_t   buttons,
	input  wire invader_pkg::pixel_pos_t  scan_pos,
	input  wire invader_pkg::target_set_t targets,
	output invader_pkg::sprite_pix_t      ship_pix,
	output invader_pkg::sprite_pix_t      laser_pix,
	output invader_pkg::pixel_pos_t       laser_pos
);

	import invader_pkg::*;

	logic   frame_tick;
	logic   play_clear;
	logic   shoot_req;
	coord_t ship_x;
	logic   laser_active;
	logic   hit;

	//////////////////////////////////////////////////
	// Decode and ship
	//////////////////////////////////////////////////

	ship_controls ship_controls_i (
		.clk        (clk),
		.reset      (reset),
		.restart    (restart),
		.mode       (mode),
		.buttons    (buttons),
		.scan_pos   (scan_pos),
		.frame_tick (frame_tick),
		.play_clear (play_clear),
		.ship_x     (ship_x),
		.shoot_req  (shoot_req)
	);

	//////////////////////////////////////////////////
	// Shot and collisions
	//////////////////////////////////////////////////

	laser_track laser_track_i (
		.clk          (clk),
		.play_clear   (play_clear),
		.frame_tick   (frame_tick),
		.shoot_req    (shoot_req),
		.ship_x       (ship_x),
		.hit          (hit),
		.laser_pos    (laser_pos),
		.laser_active (laser_active)
	);

	target_hit target_hit_i (
		.laser_pos    (laser_pos),
		.laser_active (laser_active),
		.targets      (targets),
		.hit          (hit)
	);

	// Pixel output stage
	pixel_render pixel_render_i (
		.clk          (clk),
		.reset        (reset),
		.scan_pos     (scan_pos),
		.ship_x       (ship_x),
		.laser_pos    (laser_pos),
		.laser_active (laser_active),
		.ship_pix     (ship_pix),
		.laser_pix    (laser_pix)
	);

endmodule

`default_nettype wire

//--- bench/ship_laser_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ship_laser_chk (
	input wire                           clk,
	input wire                           reset,
	input wire                           play_clear,
	input wire                           laser_active,
	input wire invader_pkg::coord_t      ship_x,
	input wire invader_pkg::pixel_pos_t  laser_pos,
	input wire invader_pkg::sprite_pix_t laser_pix
);

	import invader_pkg::*;

	localparam coord_t X_LO = SCREEN_LEFT + SHIP_LENGTH / 2;
	localparam coord_t X_HI = SCREEN_RIGHT - SHIP_LENGTH / 2;

	// Ship centre never leaves its travel range
	ship_x_range: assert property (@(posedge clk) disable iff (reset)
		(ship_x >= X_LO) && (ship_x <= X_HI))
		else $error("ship_x outside %0d..%0d", X_LO, X_HI);

	// Registered laser pixel comes from a shot in flight
	laser_drawn_active: assert property (@(posedge clk) disable iff (reset)
		laser_pix.on |-> $past(laser_active))
		else $error("laser pixel drawn without an active shot");

	// Clear parks the shot on the launch row
	clear_parks_shot: assert property (@(posedge clk)
		play_clear |=> (laser_pos.y == LASER_START_Y))
		else $error("shot not parked after play clear");

endmodule

bind ship_laser_top ship_laser_chk ship_laser_chk_i (
	.clk          (clk),
	.reset        (reset),
	.play_clear   (play_clear),
	.laser_active (laser_active),
	.ship_x       (ship_x),
	.laser_pos    (laser_pos),
	.laser_pix    (laser_pix)
);

`default_nettype wire

//--- bench/tb_ship_laser.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ship_laser;

	import invader_pkg::*;

	localparam int     TICK_LIMIT = 1000;
	localparam coord_t FAR_X      = 11'd700;
	localparam coord_t FAR_Y      = 11'd500;
	localparam coord_t PARK_X     = 11'd1000;

	// Button bit order is left then right then shoot
	localparam ship_cmd_t CMD_NONE  = 3'b000;
	localparam ship_cmd_t CMD_LEFT  = 3'b100;
	localparam ship_cmd_t CMD_RIGHT = 3'b010;
	localparam ship_cmd_t CMD_BOTH  = 3'b110;
	localparam ship_cmd_t CMD_SHOOT = 3'b001;

	logic        clk;
	logic        reset;
	logic        restart;
	game_mode_t  mode;
	ship_cmd_t   buttons;
	pixel_pos_t  scan_pos;
	target_set_t targets;
	sprite_pix_t ship_pix;
	sprite_pix_t laser_pix;
	pixel_pos_t  laser_pos;

	ship_laser_top ship_laser_top_i (
		.clk       (clk),
		.reset     (reset),
		.restart   (restart),
		.mode      (mode),
		.buttons   (buttons),
		.scan_pos  (scan_pos),
		.targets   (targets),
		.ship_pix  (ship_pix),
		.laser_pix (laser_pix),
		.laser_pos (laser_pos)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic pixel_pos_t make_pos(coord_t x, coord_t y);
		pixel_pos_t p;
		p.x = x;
		p.y = y;
		return p;
	endfunction

	// All targets parked off to the right beyond any shot
	function automatic target_set_t parked_targets();
		target_set_t t;
		t.saucer = make_pos(PARK_X, 11'd0);
		for (int i = 0; i < NUM_ALIENS; i++) begin
			t.aliens[i] = make_pos(PARK_X, 11'd0);
		end
		return t;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s (got %0d, expected %0d)", $time, what,
				actual, expected);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s at %0t ns", what, $time);
		$display("Checks failed");
		$fatal(1, "wait loop timed out");
	endtask

	// Origin pixel for one cycle with the buttons held and then a far pixel
	task automatic frame_tick_pulse(input ship_cmd_t cmd);
		@(posedge clk);
		scan_pos <= make_pos(11'd0, 11'd0);
		buttons  <= cmd;
		@(posedge clk);
		scan_pos <= make_pos(FAR_X, FAR_Y);
		buttons  <= CMD_NONE;
		@(negedge clk);
	endtask

	task automatic steer(input ship_cmd_t cmd, input int n);
		repeat (n) frame_tick_pulse(cmd);
	endtask

	// Output register shows this pixel after the following edge
	task automatic scan_pixel(input coord_t x, input coord_t y);
		@(posedge clk);
		scan_pos <= make_pos(x, y);
		@(posedge clk);
		scan_pos <= make_pos(FAR_X, FAR_Y);
		@(negedge clk);
	endtask

	task automatic clear_play();
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(negedge clk);
	endtask

	task automatic set_mode(input game_mode_t m);
		@(posedge clk);
		mode <= m;
		@(negedge clk);
	endtask

	task automatic set_targets(input target_set_t t);
		@(posedge clk);
		targets <= t;
		@(negedge clk);
	endtask

	task automatic fire_and_check_x(input coord_t exp_x, input string what);
		frame_tick_pulse(CMD_SHOOT);
		check_eq(32'(laser_pos.x), 32'(exp_x), what);
		check_eq(32'(laser_pos.y), 32'd417, "launch row");
	endtask

	task automatic wait_for_y(input coord_t y);
		int count;
		count = 0;
		while (laser_pos.y != y) begin
			if (count >= TICK_LIMIT) begin
				report_timeout($sformatf("laser y %0d", y));
			end else begin
				frame_tick_pulse(CMD_NONE);
				count = count + 1;
			end
		end
	endtask

	// Shot drawn at the spot until one tick retires it
	task automatic check_retire(input coord_t x, input coord_t y, input string what);
		scan_pixel(x, y);
		check_eq(32'(laser_pix.on), 32'd1, {what, ": shot drawn before hit"});
		frame_tick_pulse(CMD_NONE);
		check_eq(32'(laser_pos.y), 32'd417, {what, ": shot back at ship row"});
		check_eq(32'(laser_pos.x), 32'(x), {what, ": shot back at ship column"});
		scan_pixel(x, y);
		check_eq(32'(laser_pix.on), 32'd0, {what, ": shot gone after hit"});
		check_eq(32'(laser_pix.rgb), 32'd0, {what, ": no laser colour"});
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check_eq(32'(laser_pos.x), 32'd320, "reset laser x");
		check_eq(32'(laser_pos.y), 32'd417, "reset laser y");
		check_eq(32'(laser_pix.on), 32'd0, "reset laser pixel");
		scan_pixel(11'd320, 11'd425);
		check_eq(32'(ship_pix.on), 32'd1, "ship centre covered");
		check_eq(32'(ship_pix.rgb), 32'h78, "ship colour");
		scan_pixel(11'd340, 11'd425);
		check_eq(32'(ship_pix.on), 32'd1, "ship right edge covered");
		scan_pixel(11'd341, 11'd425);
		check_eq(32'(ship_pix.on), 32'd0, "past ship right edge");
		check_eq(32'(ship_pix.rgb), 32'd0, "no ship colour");
		scan_pixel(11'd320, 11'd419);
		check_eq(32'(ship_pix.on), 32'd0, "above ship row");
	endtask

	task automatic test_steer_clamp();
		clear_play();
		steer(CMD_LEFT, 10);
		fire_and_check_x(11'd310, "ten steps left");
		steer(CMD_RIGHT, 400);
		fire_and_check_x(11'd620, "clamped at right edge");
		steer(CMD_LEFT, 620);
		fire_and_check_x(11'd20, "clamped at left edge");
		clear_play();
		steer(CMD_BOTH, 5);
		fire_and_check_x(11'd325, "right wins over left");
	endtask

	task automatic test_climb();
		clear_play();
		fire_and_check_x(11'd320, "launch from centre");
		for (int i = 1; i <= 5; i++) begin
			frame_tick_pulse(CMD_NONE);
			check_eq(32'(laser_pos.y), 32'(417 - i), "climb one row per tick");
		end
		scan_pixel(11'd320, 11'd412);
		check_eq(32'(laser_pix.on), 32'd1, "shot centre covered");
		check_eq(32'(laser_pix.rgb), 32'hFF, "laser colour");
		scan_pixel(11'd322, 11'd412);
		check_eq(32'(laser_pix.on), 32'd0, "past shot width");
		scan_pixel(11'd320, 11'd417);
		check_eq(32'(laser_pix.on), 32'd1, "shot lower edge covered");
		scan_pixel(11'd320, 11'd418);
		check_eq(32'(laser_pix.on), 32'd0, "below shot");
	endtask

	task automatic test_target_hits();
		target_set_t t;
		t = parked_targets();
		t.aliens[3] = make_pos(11'd200, 11'd200);
		set_targets(t);
		clear_play();
		steer(CMD_LEFT, 120);
		fire_and_check_x(11'd200, "aim at alien");
		wait_for_y(11'd209);
		check_retire(11'd200, 11'd209, "alien hit");

		// A shot one pixel beyond the alien edge flies on to the ceiling
		clear_play();
		steer(CMD_LEFT, 104);
		fire_and_check_x(11'd216, "aim beside alien");
		wait_for_y(11'd46);
		check_retire(11'd216, 11'd46, "ceiling hit");

		t = parked_targets();
		t.saucer = make_pos(11'd400, 11'd100);
		set_targets(t);
		clear_play();
		steer(CMD_RIGHT, 80);
		fire_and_check_x(11'd400, "aim at saucer");
		wait_for_y(11'd108);
		check_retire(11'd400, 11'd108, "saucer hit");
		set_targets(parked_targets());
	endtask

	task automatic test_mode_restart();
		game_mode_t idle_modes [3];
		idle_modes[0] = MODE_IDLE_0;
		idle_modes[1] = MODE_IDLE_1;
		idle_modes[2] = MODE_IDLE_3;
		foreach (idle_modes[k]) begin
			clear_play();
			steer(CMD_RIGHT, 5);
			fire_and_check_x(11'd325, "ship moved before idle");
			steer(CMD_NONE, 3);
			set_mode(idle_modes[k]);
			steer(CMD_RIGHT, 3);
			check_eq(32'(laser_pos.x), 32'd320, "idle clears shot x");
			check_eq(32'(laser_pos.y), 32'd417, "idle clears shot y");
			scan_pixel(11'd320, 11'd414);
			check_eq(32'(laser_pix.on), 32'd0, "no shot in idle");
			scan_pixel(11'd341, 11'd425);
			check_eq(32'(ship_pix.on), 32'd0, "ship recentred in idle");
			set_mode(MODE_PLAY);
			fire_and_check_x(11'd320, "idle ticks move nothing");
		end
		clear_play();
		steer(CMD_RIGHT, 7);
		fire_and_check_x(11'd327, "ship moved before restart");
		steer(CMD_NONE, 2);
		clear_play();
		check_eq(32'(laser_pos.x), 32'd320, "restart clears shot x");
		check_eq(32'(laser_pos.y), 32'd417, "restart clears shot y");
		scan_pixel(11'd341, 11'd425);
		check_eq(32'(ship_pix.on), 32'd0, "ship recentred by restart");
		fire_and_check_x(11'd320, "fire after restart");
	endtask

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		restart  = 1'b0;
		mode     = MODE_PLAY;
		buttons  = CMD_NONE;
		scan_pos = make_pos(FAR_X, FAR_Y);
		targets  = parked_targets();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		test_reset_state();
		test_steer_clamp();
		test_climb();
		test_target_hits();
		test_mode_restart();

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/invader_pkg.sv
src/ship_controls.sv
src/target_hit.sv
src/laser_track.sv
src/pixel_render.sv
src/ship_laser_top.sv
bench/ship_laser_chk.sv
bench/tb_ship_laser.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ship_laser
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
SIM_BIN  = $(BUILD)/V$(TOP)
SOURCES  = $(wildcard src/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
